// File: rvIsaPkg.sv
package rvIsaPkg;

   localparam int xlen     = 32;
   localparam int regAddrW = 5;

   // Instruction field positions
   localparam int opcodeLsb = 0;
   localparam int opcodeW   = 7;
   localparam int rdLsb     = 7;
   localparam int funct3Lsb = 12;
   localparam int funct3W   = 3;
   localparam int rs1Lsb    = 15;
   localparam int rs2Lsb    = 20;
   localparam int funct7Lsb = 25;
   localparam int funct7W   = 7;

   localparam logic [funct3W-1:0] f3AddSub = 3'b000;
   localparam logic [funct3W-1:0] f3Sll    = 3'b001;
   localparam logic [funct3W-1:0] f3Word   = 3'b010; // LW and SW
   localparam logic [funct3W-1:0] f3Or     = 3'b110;
   localparam logic [funct3W-1:0] f3And    = 3'b111;

   localparam logic [funct7W-1:0] f7Base = 7'b0000000;
   localparam logic [funct7W-1:0] f7Alt  = 7'b0100000; // SUB

   typedef enum logic [opcodeW-1:0] {
      opcLoad  = 7'b0000011,
      opcOpImm = 7'b0010011,
      opcStore = 7'b0100011,
      opcOp    = 7'b0110011,
      opcLui   = 7'b0110111,
      opcHalt  = 7'h7F
   } opcodeE;

   typedef enum logic [3:0] {
      opNop, opLui, opAdd, opSub, opSll, opAddi, opOri, opAndi, opLw, opSw, opHalt
   } opE;

   typedef struct packed {
      opE                  op;
      logic [regAddrW-1:0] rd;
      logic [regAddrW-1:0] rs1;
      logic [regAddrW-1:0] rs2;
      logic [xlen-1:0]     imm; // Already extended
   } decodedT;

endpackage

// File: memBusPkg.sv
package memBusPkg;

   localparam int addrW = rvIsaPkg::xlen; // Word address
   localparam int dataW = rvIsaPkg::xlen;

   typedef struct packed {
      logic             valid;
      logic             we;
      logic [addrW-1:0] addr;
      logic [dataW-1:0] wdata;
   } memReqT;

   typedef struct packed {
      logic             valid;
      logic [dataW-1:0] rdata;
   } memRspT;

   // Single-cycle data strobe from the execute stage
   typedef struct packed {
      logic                          valid;
      logic                          write;
      logic [addrW-1:0]              addr;
      logic [dataW-1:0]              wdata;
      logic [rvIsaPkg::regAddrW-1:0] rd;
   } memCmdT;

   typedef struct packed {
      logic                          en;
      logic [rvIsaPkg::regAddrW-1:0] idx;
      logic [dataW-1:0]              data;
   } regWrT;

endpackage

// File: fetchSequencer.sv
`timescale 1ns/1ps

module fetchSequencer (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      start,
   input  rvIsaPkg::decodedT         decoded,
   input  logic                      fetchDone,
   input  logic [rvIsaPkg::xlen-1:0] fetchData,
   input  logic                      busy,
   output logic                      fetchStrobe,
   output logic [rvIsaPkg::xlen-1:0] pc,
   output logic [rvIsaPkg::xlen-1:0] instr,
   output logic                      execEn,
   output logic                      halted
);
   import rvIsaPkg::*;

   typedef enum logic [1:0] {
      seqHalt,
      seqFetch, // Waiting for instruction word
      seqExec,
      seqWait   // Data access or settle cycle
   } seqStateE;

   seqStateE state;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= seqHalt;
         halted <= 1'b1;
         pc     <= '0;
      end
      else begin
         case (state)
            seqHalt: begin
               if (start) begin
                  state  <= seqWait;
                  halted <= 1'b0;
                  pc     <= '0;
               end
            end
            seqFetch: begin
               if (fetchDone) begin
                  state <= seqExec;
               end
            end
            seqExec: begin
               if (decoded.op == opHalt) begin
                  state  <= seqHalt;
                  halted <= 1'b1;
               end
               else begin
                  state <= seqWait;
                  pc    <= pc + 1; // Word addressed
               end
            end
            default: begin
               if (!busy) begin
                  state <= seqFetch;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == seqFetch && fetchDone) begin
         instr <= fetchData;
      end
   end

   assign fetchStrobe = (state == seqWait) && !busy;
   assign execEn      = state == seqExec;

   // Memory unit takes each fetch at once
   strobeAccepted: assert property (@(posedge clk) disable iff (!rstn)
      fetchStrobe |=> busy);

endmodule

// File: instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
   input  logic [rvIsaPkg::xlen-1:0] instr,
   output rvIsaPkg::decodedT         decoded
);
   import rvIsaPkg::*;

   opcodeE              opcode;
   logic [funct3W-1:0]  funct3;
   logic [funct7W-1:0]  funct7;
   logic [xlen-1:0]     immI;
   logic [xlen-1:0]     immS;
   logic [xlen-1:0]     immU;

   assign opcode = opcodeE'(instr[opcodeLsb +: opcodeW]);
   assign funct3 = instr[funct3Lsb +: funct3W];
   assign funct7 = instr[funct7Lsb +: funct7W];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immU = {12'b0, instr[31:12]}; // Shifted up in execUnit

   always_comb begin
      decoded.op  = opNop;
      decoded.rd  = instr[rdLsb +: regAddrW];
      decoded.rs1 = instr[rs1Lsb +: regAddrW];
      decoded.rs2 = instr[rs2Lsb +: regAddrW];
      decoded.imm = immI;

      case (opcode)
         opcOpImm: begin
            case (funct3)
               f3AddSub: decoded.op = opAddi;
               f3Or:     decoded.op = opOri;
               f3And:    decoded.op = opAndi;
               default:  decoded.op = opNop;
            endcase
         end
         opcOp: begin
            if (funct7 == f7Base && funct3 == f3AddSub) begin
               decoded.op = opAdd;
            end
            else if (funct7 == f7Base && funct3 == f3Sll) begin
               decoded.op = opSll;
            end
            else if (funct7 == f7Alt && funct3 == f3AddSub) begin
               decoded.op = opSub;
            end
         end
         opcLui: begin
            decoded.op  = opLui;
            decoded.imm = immU;
         end
         opcLoad: begin
            if (funct3 == f3Word) begin
               decoded.op = opLw;
            end
         end
         opcStore: begin
            decoded.imm = immS;
            if (funct3 == f3Word) begin
               decoded.op = opSw;
            end
         end
         opcHalt: decoded.op = opHalt;
         default: decoded.op = opNop; // Unknown opcode runs as a no-op
      endcase
   end

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic [rvIsaPkg::regAddrW-1:0] rs1,
   input  logic [rvIsaPkg::regAddrW-1:0] rs2,
   output logic [rvIsaPkg::xlen-1:0]     rdata1,
   output logic [rvIsaPkg::xlen-1:0]     rdata2,
   input  memBusPkg::regWrT              wr
);
   import rvIsaPkg::*;

   logic [xlen-1:0] regs [2**regAddrW];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 2**regAddrW; i++) begin
            regs[i] <= '0;
         end
      end
      else if (wr.en && wr.idx != '0) begin // x0 stays zero
         regs[wr.idx] <= wr.data;
      end
   end

   assign rdata1 = regs[rs1];
   assign rdata2 = regs[rs2];

endmodule

// File: execUnit.sv
`timescale 1ns/1ps

module execUnit (
   input  rvIsaPkg::decodedT         decoded,
   input  logic                      execEn,
   input  logic [rvIsaPkg::xlen-1:0] rdata1,
   input  logic [rvIsaPkg::xlen-1:0] rdata2,
   input  memBusPkg::regWrT          loadWr,
   output memBusPkg::memCmdT         dataCmd,
   output memBusPkg::regWrT          regWr
);
   import rvIsaPkg::*;
   import memBusPkg::*;

   regWrT aluWr;

   // ALU
   always_comb begin
      aluWr.en   = execEn;
      aluWr.idx  = decoded.rd;
      aluWr.data = '0;
      case (decoded.op)
         opLui:   aluWr.data = {decoded.imm[19:0], 12'h000};
         opAdd:   aluWr.data = rdata1 + rdata2;
         opSub:   aluWr.data = rdata1 - rdata2;
         opSll:   aluWr.data = rdata1 << rdata2[4:0];
         opAddi:  aluWr.data = rdata1 + decoded.imm;
         opOri:   aluWr.data = rdata1 | decoded.imm;
         opAndi:  aluWr.data = rdata1 & decoded.imm;
         default: aluWr.en   = 1'b0; // Memory ops, halt and no-ops
      endcase
   end

   assign dataCmd.valid = execEn && (decoded.op == opLw || decoded.op == opSw);
   assign dataCmd.write = decoded.op == opSw;
   assign dataCmd.addr  = rdata1 + decoded.imm;
   assign dataCmd.wdata = rdata2;
   assign dataCmd.rd    = decoded.rd;

   // Load data arrives only after the execute cycle
   assign regWr = execEn ? aluWr : loadWr;

   always_comb begin
      assert final (!(aluWr.en && loadWr.en))
         else $error("ALU write and load write in the same cycle");
   end

endmodule

// File: memAccessUnit.sv
`timescale 1ns/1ps

module memAccessUnit (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      fetchStrobe,
   input  logic [rvIsaPkg::xlen-1:0] pc,
   input  memBusPkg::memCmdT         dataCmd,
   output memBusPkg::memReqT         memReq,
   input  memBusPkg::memRspT         memRsp,
   output logic                      fetchDone,
   output logic [rvIsaPkg::xlen-1:0] fetchData,
   output memBusPkg::regWrT          loadWr,
   output logic                      busy
);
   import rvIsaPkg::*;
   import memBusPkg::*;

   typedef enum logic [1:0] {accFetch, accLoad, accStore} accKindE;

   memReqT              reqQ;
   accKindE             kind;
   logic [regAddrW-1:0] loadRd;
   logic                rspHit;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reqQ.valid <= 1'b0;
         kind       <= accFetch;
      end
      else if (reqQ.valid) begin
         if (memRsp.valid) begin
            reqQ.valid <= 1'b0; // Drop at the edge that takes the response
         end
      end
      else if (fetchStrobe) begin
         reqQ <= '{valid: 1'b1, we: 1'b0, addr: pc, wdata: '0};
         kind <= accFetch;
      end
      else if (dataCmd.valid) begin
         reqQ <= '{valid: 1'b1, we: dataCmd.write, addr: dataCmd.addr, wdata: dataCmd.wdata};
         kind <= dataCmd.write ? accStore : accLoad;
      end
   end

   always_ff @(posedge clk) begin
      if (!reqQ.valid && !fetchStrobe && dataCmd.valid) begin
         loadRd <= dataCmd.rd;
      end
   end

   assign rspHit = reqQ.valid && memRsp.valid;

   assign memReq      = reqQ;
   assign busy        = reqQ.valid;
   assign fetchDone   = rspHit && kind == accFetch;
   assign fetchData   = memRsp.rdata;
   assign loadWr.en   = rspHit && kind == accLoad;
   assign loadWr.idx  = loadRd;
   assign loadWr.data = memRsp.rdata;

   oneSource: assert property (@(posedge clk) disable iff (!rstn)
      !(fetchStrobe && dataCmd.valid));

endmodule

// File: rvMiniCore.sv
`timescale 1ns/1ps

module rvMiniCore (
   input  logic              clk,
   input  logic              rstn,
   input  logic              start,
   output logic              halted,
   output memBusPkg::memReqT memReq,
   input  memBusPkg::memRspT memRsp
);
   import rvIsaPkg::*;
   import memBusPkg::*;

   decodedT         decoded;
   logic [xlen-1:0] pc;
   logic [xlen-1:0] instr;
   logic [xlen-1:0] fetchData;
   logic [xlen-1:0] rdata1;
   logic [xlen-1:0] rdata2;
   logic            fetchStrobe;
   logic            fetchDone;
   logic            execEn;
   logic            busy;
   memCmdT          dataCmd;
   regWrT           loadWr;
   regWrT           regWr;

   fetchSequencer i_fetchSequencer (
      .clk         (clk),
      .rstn        (rstn),
      .start       (start),
      .decoded     (decoded),
      .fetchDone   (fetchDone),
      .fetchData   (fetchData),
      .busy        (busy),
      .fetchStrobe (fetchStrobe),
      .pc          (pc),
      .instr       (instr),
      .execEn      (execEn),
      .halted      (halted)
   );

   instrDecoder i_instrDecoder (
      .instr   (instr),
      .decoded (decoded)
   );

   regFile i_regFile (
      .clk    (clk),
      .rstn   (rstn),
      .rs1    (decoded.rs1),
      .rs2    (decoded.rs2),
      .rdata1 (rdata1),
      .rdata2 (rdata2),
      .wr     (regWr)
   );

   execUnit i_execUnit (
      .decoded (decoded),
      .execEn  (execEn),
      .rdata1  (rdata1),
      .rdata2  (rdata2),
      .loadWr  (loadWr),
      .dataCmd (dataCmd),
      .regWr   (regWr)
   );

   memAccessUnit i_memAccessUnit (
      .clk         (clk),
      .rstn        (rstn),
      .fetchStrobe (fetchStrobe),
      .pc          (pc),
      .dataCmd     (dataCmd),
      .memReq      (memReq),
      .memRsp      (memRsp),
      .fetchDone   (fetchDone),
      .fetchData   (fetchData),
      .loadWr      (loadWr),
      .busy        (busy)
   );

endmodule

// File: tbMemory.sv
`timescale 1ns/1ps

module tbMemory (
   input  logic              clk,
   input  logic              rstn,
   input  memBusPkg::memReqT memReq,
   output memBusPkg::memRspT memRsp,
   output int                protocolErrors
);
   import memBusPkg::*;

   logic [dataW-1:0] mem [256];
   logic [31:0]      lfsr;
   memReqT           heldReq;
   logic             holding; // Request accepted and response still pending
   int               waitLeft;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic respond();
      memRsp.valid = 1'b1;
      memRsp.rdata = mem[memReq.addr[7:0]];
      if (memReq.we) begin
         mem[memReq.addr[7:0]] = memReq.wdata;
      end
      holding = 1'b0;
   endtask

   initial begin
      lfsr           = 32'h11ba_7e41;
      memRsp         = '0;
      holding        = 1'b0;
      waitLeft       = 0;
      protocolErrors = 0;
   end

   // Response is driven on the falling edge and sampled by the core on the rising one
   always @(negedge clk) begin
      logic [1:0] lat;
      if (!rstn) begin
         memRsp.valid = 1'b0;
         holding      = 1'b0;
      end
      else begin
         if (holding && memReq !== heldReq) begin
            protocolErrors++;
            $display("request fields changed while a response was pending at %0t", $time);
         end
         if (memRsp.valid) begin
            memRsp.valid = 1'b0; // Taken at the last rising edge
         end
         else if (holding) begin
            if (waitLeft == 0) begin
               respond();
            end
            else begin
               waitLeft--;
            end
         end
         else if (memReq.valid) begin
            lfsr    = lfsrStep(lfsr);
            lat[0]  = lfsr[0];
            lfsr    = lfsrStep(lfsr);
            lat[1]  = lfsr[0];
            heldReq = memReq;
            if (lat == 2'd0) begin
               respond(); // One cycle latency
            end
            else begin
               holding  = 1'b1;
               waitLeft = int'(lat) - 1;
            end
         end
      end
   end

endmodule

// File: rvMiniCoreTb.sv
`timescale 1ns/1ps

module rvMiniCoreTb;
   import rvIsaPkg::*;
   import memBusPkg::*;

   localparam int numTests = 5;
   localparam int progLen  = 8;
   localparam int haltWait = 1000;

   logic   clk;
   logic   rstn;
   logic   start;
   logic   halted;
   memReqT memReq;
   memRspT memRsp;
   int     protocolErrors;
   int     passCount;
   int     failCount;

   string       testName  [numTests];
   logic [31:0] progWords [numTests][progLen];
   logic [7:0]  preAddr   [numTests];
   logic [31:0] preData   [numTests];
   logic [7:0]  checkAddr [numTests];
   logic [31:0] expected  [numTests];

   rvMiniCore i_rvMiniCore (
      .clk    (clk),
      .rstn   (rstn),
      .start  (start),
      .halted (halted),
      .memReq (memReq),
      .memRsp (memRsp)
   );

   tbMemory i_mem (
      .clk            (clk),
      .rstn           (rstn),
      .memReq         (memReq),
      .memRsp         (memRsp),
      .protocolErrors (protocolErrors)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] regOp(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, opcOp};
   endfunction

   function automatic logic [31:0] immOp(input logic [6:0] opc, input logic [11:0] imm,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] storeOp(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, f3Word, imm[4:0], opcStore};
   endfunction

   function automatic logic [31:0] luiOp(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, opcLui};
   endfunction

   function automatic logic [31:0] haltOp();
      return {25'b0, opcHalt};
   endfunction

   task automatic buildTable();
      for (int t = 0; t < numTests; t++) begin
         for (int w = 0; w < progLen; w++) begin
            progWords[t][w] = haltOp();
         end
         preAddr[t] = 8'd48;
         preData[t] = 32'h0BAD_CAFE;
      end
      // 0x12345000 minus 16 then OR 0xF and AND 0xFFFFFF0F
      testName[0]     = "lui_imm";
      progWords[0][0] = luiOp(20'h12345, 5'd1);
      progWords[0][1] = immOp(opcOpImm, 12'hFF0, 5'd1, f3AddSub, 5'd1);
      progWords[0][2] = immOp(opcOpImm, 12'h00F, 5'd1, f3Or, 5'd1);
      progWords[0][3] = immOp(opcOpImm, 12'hF0F, 5'd1, f3And, 5'd1);
      progWords[0][4] = storeOp(12'd64, 5'd1, 5'd0);
      checkAddr[0]    = 8'd64;
      expected[0]     = 32'h12344F0F;
      // (67 - 100) shifted left by 67 & 31 plus 167
      testName[1]     = "add_sub_sll";
      progWords[1][0] = immOp(opcOpImm, 12'h043, 5'd0, f3AddSub, 5'd2);
      progWords[1][1] = immOp(opcOpImm, 12'd100, 5'd0, f3AddSub, 5'd1);
      progWords[1][2] = regOp(f7Base, 5'd2, 5'd1, f3AddSub, 5'd3);
      progWords[1][3] = regOp(f7Alt, 5'd1, 5'd2, f3AddSub, 5'd4);
      progWords[1][4] = regOp(f7Base, 5'd2, 5'd4, f3Sll, 5'd5);
      progWords[1][5] = regOp(f7Base, 5'd3, 5'd5, f3AddSub, 5'd5);
      progWords[1][6] = storeOp(12'd65, 5'd5, 5'd0);
      checkAddr[1]    = 8'd65;
      expected[1]     = 32'hFFFFFF9F;
      // Negative offsets from base 80
      testName[2]     = "load_copy";
      progWords[2][0] = immOp(opcOpImm, 12'd80, 5'd0, f3AddSub, 5'd6);
      progWords[2][1] = immOp(opcLoad, 12'hFE0, 5'd6, f3Word, 5'd7);
      progWords[2][2] = storeOp(12'hFF2, 5'd7, 5'd6);
      preData[2]      = 32'hCAFE_F00D;
      checkAddr[2]    = 8'd66;
      expected[2]     = 32'hCAFE_F00D;
      testName[3]     = "x0_and_unknown";
      progWords[3][0] = immOp(opcOpImm, 12'd55, 5'd0, f3AddSub, 5'd0);
      progWords[3][1] = immOp(7'b0001011, 12'h7FF, 5'd0, f3AddSub, 5'd8);
      progWords[3][2] = regOp(f7Base, 5'd8, 5'd0, f3AddSub, 5'd9);
      progWords[3][3] = storeOp(12'd67, 5'd9, 5'd0);
      checkAddr[3]    = 8'd67;
      expected[3]     = 32'h0;
      testName[4]     = "halt_only";
      progWords[4][1] = storeOp(12'd48, 5'd0, 5'd0); // Must not run after HALT
      checkAddr[4]    = 8'd48;
      expected[4]     = 32'h0BAD_CAFE;
   endtask

   task automatic loadMemory(input int t);
      for (int a = 0; a < 256; a++) begin
         i_mem.mem[a] = {8'hA5, a[7:0], ~a[7:0], a[7:0]};
      end
      for (int w = 0; w < progLen; w++) begin
         i_mem.mem[w] = progWords[t][w];
      end
      i_mem.mem[preAddr[t]] = preData[t];
   endtask

   task automatic runTest(input int t);
      int          errs;
      int          cycles;
      logic [31:0] actual;
      errs = 0;
      rstn = 1'b0;
      loadMemory(t);
      repeat (2) @(negedge clk);
      rstn = 1'b1;
      for (int i = 0; i < 3; i++) begin
         @(negedge clk);
         if (!halted || memReq.valid) begin
            $display("test %s: core not idle and halted before start", testName[t]);
            errs++;
         end
      end
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      if (halted) begin
         $display("test %s: halted did not fall after start", testName[t]);
         errs++;
      end
      cycles = 0;
      while (!halted && cycles < haltWait) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("test %s: timed out waiting for halted", testName[t]);
         errs++;
      end
      else begin
         for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (memReq.valid) begin
               $display("test %s: memory request issued after halt", testName[t]);
               errs++;
            end
         end
         actual = i_mem.mem[checkAddr[t]];
         if (actual !== expected[t]) begin
            $display("mismatch %s: expected %h, actual %h", testName[t], expected[t], actual);
            errs++;
         end
      end
      if (errs == 0) begin
         passCount++;
         $display("test %s passed", testName[t]);
      end
      else begin
         failCount++;
         $display("test %s failed", testName[t]);
      end
   endtask

   initial begin
      rstn      = 1'b0;
      start     = 1'b0;
      passCount = 0;
      failCount = 0;
      buildTable();
      @(negedge clk);
      for (int t = 0; t < numTests; t++) begin
         runTest(t);
      end
      $display("%0d tests passed, %0d failed, %0d protocol errors",
               passCount, failCount, protocolErrors);
      if (failCount == 0 && protocolErrors == 0) begin
         $display("Everything OK");
      end
      else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: rvMiniCore.f
rvIsaPkg.sv
memBusPkg.sv
fetchSequencer.sv
instrDecoder.sv
regFile.sv
execUnit.sv
memAccessUnit.sv
rvMiniCore.sv
tbMemory.sv
rvMiniCoreTb.sv

// File: Makefile
TOP = rvMiniCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f rvMiniCore.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f rvMiniCore.f -o simv
	./obj_dir/simv > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "Something failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
